// ==== adder_pkg.sv ====
package adder_pkg;

    // Default operand width, the top level passes it down as a parameter
    localparam int DATA_W = 4;

    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } add_op_e;

    // One operation entering the adder
    typedef struct packed {
        add_op_e           op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } add_req_t;

    // For OP_SUB, carry set means no borrow (a >= b)
    typedef struct packed {
        logic [DATA_W-1:0] sum;
        logic              carry;
    } add_rsp_t;

endpackage

// ==== cla_adder_pipe.sv ====
module cla_adder_pipe
    import adder_pkg::*;
#(
    parameter int DATA_W = adder_pkg::DATA_W
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  add_req_t in_req,
    output logic     res_valid,
    input  logic     res_ready,
    output add_rsp_t res_rsp
);

    logic stall;

    // Input register
    logic              s1_valid;
    add_op_e           s1_op;
    logic [DATA_W-1:0] s1_a;
    logic [DATA_W-1:0] s1_b;

    // Propagate/generate stage
    logic              s2_valid;
    logic [DATA_W-1:0] s2_p;
    logic [DATA_W-1:0] s2_g;
    logic              s2_cin;
    logic [DATA_W-1:0] b_eff;

    // Carry stage
    logic              s3_valid;
    logic [DATA_W-1:0] s3_p;
    logic [DATA_W:0]   s3_c;
    logic [DATA_W:0]   carry_c;

    // Sum stage
    logic              s4_valid;
    add_rsp_t          s4_rsp;

    // Only a full last stage facing a refusing FIFO holds the pipe
    assign stall    = s4_valid && !res_ready;
    assign in_ready = !stall;

    assign res_valid = s4_valid;
    assign res_rsp   = s4_rsp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            s4_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            s4_valid <= s3_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && in_valid) begin
            s1_op <= in_req.op;
            s1_a  <= in_req.a;
            s1_b  <= in_req.b;
        end
    end

    // Subtract as a + ~b + 1
    assign b_eff = (s1_op == OP_SUB) ? ~s1_b : s1_b;

    always_ff @(posedge clk) begin
        if (!stall && s1_valid) begin
            s2_p   <= s1_a ^ b_eff;
            s2_g   <= s1_a & b_eff;
            s2_cin <= (s1_op == OP_SUB);
        end
    end

    // Each carry is a flat sum of generate terms, no ripple between bits
    for (genvar i = 0; i <= DATA_W; i++) begin : g_carry
        logic c_i;

        always_comb begin : carry_term
            logic prop;
            c_i  = 1'b0;
            prop = 1'b1;
            for (int j = i - 1; j >= 0; j--) begin
                c_i  = c_i | (prop & s2_g[j]);
                prop = prop & s2_p[j];
            end
            c_i = c_i | (prop & s2_cin);
        end

        assign carry_c[i] = c_i;
    end

    always_ff @(posedge clk) begin
        if (!stall && s2_valid) begin
            s3_p <= s2_p;
            s3_c <= carry_c;
        end
    end

    // Carry-out doubles as the no-borrow flag for subtraction
    always_ff @(posedge clk) begin
        if (!stall && s3_valid) begin
            s4_rsp.sum   <= s3_p ^ s3_c[DATA_W-1:0];
            s4_rsp.carry <= s3_c[DATA_W];
        end
    end

endmodule

// ==== result_fifo.sv ====
module result_fifo
    import adder_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     res_valid,
    output logic     res_ready,
    input  add_rsp_t res_rsp,
    output logic     q_valid,
    input  logic     q_ready,
    output add_rsp_t q_rsp
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    add_rsp_t mem [FIFO_DEPTH];

    // Extra top bit tells a full buffer from an empty one
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic full;
    logic empty;
    logic do_write;
    logic do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // No write when full, even with a read on the same edge
    assign res_ready = !full;
    assign q_valid   = !empty;
    assign q_rsp     = mem[rd_ptr[ADDR_W-1:0]];

    assign do_write = res_valid && res_ready;
    assign do_read  = q_valid && q_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_W-1:0]] <= res_rsp;
        end
    end

endmodule

// ==== sum_accumulator.sv ====
module sum_accumulator
    import adder_pkg::*;
#(
    parameter int DATA_W  = adder_pkg::DATA_W,
    parameter int TOTAL_W = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               q_valid,
    output logic               q_ready,
    input  add_rsp_t           q_rsp,
    output logic               out_valid,
    input  logic               out_ready,
    output add_rsp_t           out_rsp,
    output logic [TOTAL_W-1:0] total
);

    logic              pop;
    logic              deliver;
    logic [DATA_W-1:0] delivered_sum;

    assign deliver = out_valid && out_ready;

    // Free when empty or emptying this cycle
    assign q_ready = !out_valid || out_ready;
    assign pop     = q_valid && q_ready;

    assign delivered_sum = out_rsp.sum;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;
        end else if (deliver) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_rsp <= q_rsp;
        end
    end

    // Wraps modulo 2^TOTAL_W
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            total <= '0;
        end else if (deliver) begin
            total <= total + TOTAL_W'(delivered_sum);
        end
    end

endmodule

// ==== adder_subsystem_top.sv ====
module adder_subsystem_top
    import adder_pkg::*;
#(
    parameter int DATA_W     = adder_pkg::DATA_W,
    parameter int FIFO_DEPTH = 4,
    parameter int TOTAL_W    = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  add_req_t           in_req,
    output logic               out_valid,
    input  logic               out_ready,
    output add_rsp_t           out_rsp,
    output logic [TOTAL_W-1:0] total
);

    // Adder to FIFO
    logic     res_valid;
    logic     res_ready;
    add_rsp_t res_rsp;

    // FIFO to accumulator
    logic     q_valid;
    logic     q_ready;
    add_rsp_t q_rsp;

    cla_adder_pipe #(
        .DATA_W (DATA_W)
    ) cla_adder_pipe_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_rsp   (res_rsp)
    );

    result_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) result_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_rsp   (res_rsp),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_rsp     (q_rsp)
    );

    sum_accumulator #(
        .DATA_W  (DATA_W),
        .TOTAL_W (TOTAL_W)
    ) sum_accumulator_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_rsp     (q_rsp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp),
        .total     (total)
    );

endmodule

// ==== adder_subsystem_assert.sv ====
module adder_subsystem_assert
    import adder_pkg::*;
#(
    parameter int TOTAL_W = 8
) (
    input logic               clk,
    input logic               rst_n,
    input logic               in_ready,
    input logic               out_valid,
    input logic               out_ready,
    input add_rsp_t           out_rsp,
    input logic [TOTAL_W-1:0] total,
    input logic               res_valid,
    input logic               res_ready,
    input add_rsp_t           res_rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    reset_clears_out: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // Stalled output must hold its data
    out_rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_rsp))
        else $error("out_rsp changed while out_ready was low");

    // A stall blocks new input and freezes the adder's result
    stall_blocks_input: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> $past(!in_ready) && res_valid && $stable(res_rsp))
        else $error("in_ready high or adder result changed while the adder was stalled");

    total_only_on_delivery: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid && out_ready) |=> $stable(total))
        else $error("total changed without a delivery");

endmodule

bind adder_subsystem_top adder_subsystem_assert #(
    .TOTAL_W (TOTAL_W)
) adder_subsystem_assert_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp),
    .total     (total),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_rsp   (res_rsp)
);

// ==== tb_adder_subsystem.sv ====
module tb_adder_subsystem
    import adder_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TOTAL_W         = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_ROWS        = 16;
    localparam int HOLD_CYCLES     = 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + HOLD_CYCLES + 2 * NUM_ROWS * 40;
    localparam logic [31:0] SEED   = 32'd65373;

    typedef struct packed {
        add_op_e           op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] sum;
        logic              carry;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    add_req_t           in_req;
    logic               out_valid;
    logic               out_ready;
    add_rsp_t           out_rsp;
    logic [TOTAL_W-1:0] total;

    row_t               rows[$];
    string              row_names[$];
    int                 exp_q[$];
    logic [TOTAL_W-1:0] exp_total = '0;
    int                 sent_count = 0;
    int                 received_count = 0;
    int                 hold_cycles = 0;
    bit                 burst_active = 1'b0;
    bit                 saw_stall = 1'b0;

    adder_subsystem_top adder_subsystem_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp),
        .total     (total)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_test(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic add_row(input string name, input add_op_e op, input logic [DATA_W-1:0] a,
                           input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] sum,
                           input logic carry);
        row_t r;
        r.op    = op;
        r.a     = a;
        r.b     = b;
        r.sum   = sum;
        r.carry = carry;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    // Expected sum and carry worked out by hand for 4-bit operands
    task automatic build_table();
        add_row("add_3_4",   OP_ADD, 4'd3,  4'd4,  4'd7,  1'b0);
        add_row("add_0_0",   OP_ADD, 4'd0,  4'd0,  4'd0,  1'b0);
        add_row("add_15_1",  OP_ADD, 4'd15, 4'd1,  4'd0,  1'b1);
        add_row("add_15_15", OP_ADD, 4'd15, 4'd15, 4'd14, 1'b1);
        add_row("add_8_8",   OP_ADD, 4'd8,  4'd8,  4'd0,  1'b1);
        add_row("add_7_9",   OP_ADD, 4'd7,  4'd9,  4'd0,  1'b1);
        add_row("add_5_10",  OP_ADD, 4'd5,  4'd10, 4'd15, 1'b0);
        add_row("add_12_6",  OP_ADD, 4'd12, 4'd6,  4'd2,  1'b1);
        add_row("sub_9_4",   OP_SUB, 4'd9,  4'd4,  4'd5,  1'b1);
        add_row("sub_7_7",   OP_SUB, 4'd7,  4'd7,  4'd0,  1'b1);
        add_row("sub_15_0",  OP_SUB, 4'd15, 4'd0,  4'd15, 1'b1);
        add_row("sub_3_5",   OP_SUB, 4'd3,  4'd5,  4'd14, 1'b0);
        add_row("sub_0_1",   OP_SUB, 4'd0,  4'd1,  4'd15, 1'b0);
        add_row("sub_0_15",  OP_SUB, 4'd0,  4'd15, 4'd1,  1'b0);
        add_row("sub_10_3",  OP_SUB, 4'd10, 4'd3,  4'd7,  1'b1);
        add_row("sub_6_9",   OP_SUB, 4'd6,  4'd9,  4'd13, 1'b0);
    endtask

    // Called on a rising edge, returns on the accepting edge
    task automatic send_row(input int idx);
        add_req_t req;
        req.op = rows[idx].op;
        req.a  = rows[idx].a;
        req.b  = rows[idx].b;
        in_valid <= 1'b1;
        in_req   <= req;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        exp_q.push_back(idx);
        sent_count++;
    endtask

    task automatic wait_for_drain();
        wait (received_count == sent_count);
        @(negedge clk);
        @(negedge clk);
        assert (total == exp_total)
            else abort_test($sformatf("FAIL drain_total: expected %0d, actual %0d",
                                      exp_total, total));
    endtask

    initial begin : main_seq
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (total == '0 && !out_valid)
            else abort_test("total or out_valid was not cleared by reset");
        @(posedge clk);

        // Rows back to back under random out_ready
        for (int i = 0; i < rows.size(); i++) begin
            send_row(i);
        end
        in_valid <= 1'b0;
        wait_for_drain();

        // Burst with the output blocked, so the FIFO and then the adder fill up
        @(negedge clk);
        hold_cycles  = HOLD_CYCLES;
        burst_active = 1'b1;
        @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            send_row(i);
        end
        in_valid <= 1'b0;
        wait_for_drain();
        burst_active = 1'b0;
        assert (saw_stall)
            else abort_test("in_ready never dropped while out_ready was held low");

        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin : receiver
        logic [31:0] rnd;
        add_rsp_t    exp_rsp;
        add_rsp_t    held_rsp;
        bit          held;
        bit          total_due;
        int          idx;
        string       last_name;
        rnd       = SEED;
        held      = 1'b0;
        total_due = 1'b0;
        last_name = "";
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (hold_cycles > 0) begin
                out_ready <= 1'b0;
                hold_cycles--;
            end else begin
                rnd = xorshift32(rnd);
                out_ready <= (rnd[1:0] != 2'b00);
            end
            @(negedge clk);
            if (total_due) begin
                assert (total == exp_total)
                    else abort_test($sformatf("FAIL total after %s: expected %0d, actual %0d",
                                              last_name, exp_total, total));
                total_due = 1'b0;
            end
            if (held) begin
                assert (out_valid && out_rsp == held_rsp)
                    else abort_test("out_rsp or out_valid changed while out_ready was low");
                held = 1'b0;
            end
            if (burst_active && !in_ready) begin
                saw_stall = 1'b1;
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0)
                    else abort_test("a result was delivered with no operation outstanding");
                idx           = exp_q.pop_front();
                exp_rsp.sum   = rows[idx].sum;
                exp_rsp.carry = rows[idx].carry;
                assert (out_rsp == exp_rsp)
                    else abort_test($sformatf(
                        "FAIL %s: expected sum=%0d carry=%0d, actual sum=%0d carry=%0d",
                        row_names[idx], exp_rsp.sum, exp_rsp.carry, out_rsp.sum,
                        out_rsp.carry));
                exp_total = exp_total + TOTAL_W'(rows[idx].sum);
                last_name = row_names[idx];
                total_due = 1'b1;
                received_count++;
            end else if (out_valid) begin
                held     = 1'b1;
                held_rsp = out_rsp;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_test("Simulation hung, not all results arrived before the time limit");
    end

endmodule

// ==== build.f ====
adder_pkg.sv
cla_adder_pipe.sv
result_fifo.sv
sum_accumulator.sv
adder_subsystem_top.sv
adder_subsystem_assert.sv
tb_adder_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_adder_subsystem \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    echo "Failure message found in $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
